// ==== md_core_config.svh ====
// MD core shared constants
// bus widths, cartridge header offsets, register map and reset timing

`ifndef MD_CORE_CONFIG_SVH
`define MD_CORE_CONFIG_SVH

`define MD_ROM_ADDR_W        25
`define MD_ROM_DATA_W        16
`define MD_WB_ADDR_W         8
`define MD_WB_DATA_W         32
`define MD_CART_ID_W         64     // eight ascii characters
`define MD_QUIRK_W           9
`define MD_GUN_DELAY_W       8
`define MD_PAD_W             32
`define MD_JOY_W             12

////////////////////
// header byte offsets
`define MD_HDR_ID_FIRST      'h182
`define MD_HDR_ID_LAST       'h18A
`define MD_HDR_ID_DONE       'h18C  // first word past the product code
`define MD_HDR_REGION0       'h1F0
`define MD_HDR_REGION1       'h1F2
`define MD_HDR_END           'h200

////////////////////
// register map, byte offsets
`define MD_REG_MULTITAP      'h00
`define MD_REG_AR_CORRECT    'h04
`define MD_REG_COMPOSITE     'h08
`define MD_REG_OBJ_LIMIT     'h0C
`define MD_REG_FM            'h10
`define MD_REG_PSG           'h14
`define MD_REG_HIFI_PCM      'h18
`define MD_REG_FM_CHIP       'h1C
`define MD_REG_AUDIO_FILTER  'h20
`define MD_REG_TURBO         'h24
`define MD_REG_RESET         'h28
`define MD_REG_REGION        'h30   // read only
`define MD_REG_QUIRKS        'h34   // read only
`define MD_REG_GUN           'h38   // read only

`define MD_RESET_HOLD        16     // cycles
`define MD_GUN_DELAY_DEFAULT 44

`endif

// ==== md_core_pkg.sv ====
// MD core types
// header word views, region codes and quirk bit positions

`default_nettype none

package md_core_pkg;

	// one ROM word, either as two characters or as hex digits
	typedef union packed {
		struct packed {
			logic [7:0] hi_char;    // odd address
			logic [7:0] lo_char;    // even address
		} chars;
		logic [3:0][3:0] nibbles;
	} hdr_word_u;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// bit positions in the quirk vector
	typedef enum logic [3:0] {
		QUIRK_SRAM   = 4'd0,
		QUIRK_SRAM00 = 4'd1,
		QUIRK_EEPROM = 4'd2,
		QUIRK_NORAM  = 4'd3,
		QUIRK_FIFO   = 4'd4,
		QUIRK_PIER   = 4'd5,
		QUIRK_SVP    = 4'd6,
		QUIRK_FMBUSY = 4'd7,
		QUIRK_SCHAN  = 4'd8
	} quirk_bit_e;

endpackage

`default_nettype wire

// ==== rom_header_decode.sv ====
// ROM header snooper
// watches the 16-bit word writes of a ROM download and captures the
// product code and the region field of the cartridge header

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module rom_header_decode (
	input  wire                      clk_sys,
	input  wire                      pll_core_locked,
	input  wire                      loading,
	input  wire                      rom_wr,
	input  wire [`MD_ROM_ADDR_W-1:0] rom_addr,
	input  wire [`MD_ROM_DATA_W-1:0] rom_data,
	output logic [`MD_CART_ID_W-1:0] cart_id,
	output logic                     id_done,
	output logic                     load_start,
	output wire                      hdr_j,
	output wire                      hdr_u,
	output wire                      hdr_e,
	output logic                     hdr_ready
);

	md_core_pkg::hdr_word_u word;
	logic       loading_q;
	logic       wr_en;
	logic [2:0] hdr_flags;      // {e, u, j}
	logic [2:0] lo_flags;
	logic [2:0] hi_flags;
	logic [3:0] hex_rgn;
	logic [2:0] rgn_lo;
	logic [2:0] rgn_next;

	// one-hot {e, u, j} for a region letter
	function automatic logic [2:0] jue_flags(input logic [7:0] c);
		jue_flags = {c == "E", c == "U", c == "J"};
	endfunction

	assign word     = rom_data;
	assign wr_en    = rom_wr & loading;    // only during a download
	assign lo_flags = jue_flags(word.chars.lo_char);
	assign hi_flags = jue_flags(word.chars.hi_char);
	assign hex_rgn  = word.nibbles[0] - 4'd7;  // 'A'..'F' to the region code

	assign {hdr_e, hdr_u, hdr_j} = hdr_flags;

	////////////////////
	// first region word
	always_comb begin
		if (|lo_flags)
			rgn_lo = hdr_flags | lo_flags;
		else if (word.chars.lo_char >= "0" && word.chars.lo_char <= "9")
			rgn_lo = {word.nibbles[0][3], word.nibbles[0][2], word.nibbles[0][0]};
		else if (word.chars.lo_char >= "A" && word.chars.lo_char <= "F")
			rgn_lo = {hex_rgn[3], hex_rgn[2], hex_rgn[0]};
		else
			rgn_lo = hdr_flags;
		rgn_next = rgn_lo | hi_flags;   // letter in the odd byte adds on top
	end

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			loading_q  <= 1'b0;
			load_start <= 1'b0;
			id_done    <= 1'b0;
			hdr_flags  <= 3'b000;
			hdr_ready  <= 1'b0;
		end else begin
			loading_q  <= loading;
			load_start <= loading & ~loading_q;
			id_done    <= wr_en && rom_addr == `MD_HDR_ID_DONE;

			if (load_start)
				hdr_flags <= 3'b000;
			else if (wr_en && rom_addr == `MD_HDR_REGION0)
				hdr_flags <= rgn_next;
			else if (wr_en && rom_addr == `MD_HDR_REGION1)
				hdr_flags <= hdr_flags | lo_flags;  // second word, low byte only

			if (loading_q & ~loading)
				hdr_ready <= 1'b0;
			else if (wr_en && rom_addr == `MD_HDR_END)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////
	// product code, first char sits in the odd byte of 0x182
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (rom_addr)
				`MD_HDR_ID_FIRST:     cart_id[63:56] <= word.chars.hi_char;
				`MD_HDR_ID_FIRST + 2: cart_id[55:40] <= {word.chars.lo_char, word.chars.hi_char};
				`MD_HDR_ID_FIRST + 4: cart_id[39:24] <= {word.chars.lo_char, word.chars.hi_char};
				`MD_HDR_ID_FIRST + 6: cart_id[23:8]  <= {word.chars.lo_char, word.chars.hi_char};
				`MD_HDR_ID_LAST:      cart_id[7:0]   <= word.chars.lo_char;
				default: ;
			endcase
		end
	end

	// the loader never reaches 0x18C in the first cycle of a download
	a_id_not_on_start: assert property (
		@(posedge clk_sys) disable iff (!pll_core_locked)
		!(id_done && load_start)
	);

endmodule

`default_nettype wire

// ==== cart_quirk_lookup.sv ====
// cartridge quirk lookup
// matches the captured product code against known titles and holds
// the compatibility quirk flags and light gun settings

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module cart_quirk_lookup (
	input  wire                       clk_sys,
	input  wire                       pll_core_locked,
	input  wire [`MD_CART_ID_W-1:0]   cart_id,
	input  wire                       id_done,
	input  wire                       load_start,
	output logic [`MD_QUIRK_W-1:0]    quirks,
	output logic                      gun_type,
	output logic [`MD_GUN_DELAY_W-1:0] gun_sensor_delay
);

	logic [`MD_QUIRK_W-1:0]     quirk_hit;
	logic                       gun_type_hit;
	logic [`MD_GUN_DELAY_W-1:0] gun_delay_hit;

	////////////////////
	// title table
	always_comb begin
		quirk_hit     = '0;
		gun_type_hit  = 1'b0;
		gun_delay_hit = `MD_GUN_DELAY_W'(`MD_GUN_DELAY_DEFAULT);

		case (cart_id)
			"T-081276": quirk_hit[md_core_pkg::QUIRK_SRAM]   = 1'b1;
			"MK-1215 ": quirk_hit[md_core_pkg::QUIRK_EEPROM] = 1'b1;
			"T-113016": quirk_hit[md_core_pkg::QUIRK_NORAM]  = 1'b1;  // fake ram check
			"T-89016 ": quirk_hit[md_core_pkg::QUIRK_FIFO]   = 1'b1;
			"T-574023": quirk_hit[md_core_pkg::QUIRK_PIER]   = 1'b1;
			"MK-1229 ": quirk_hit[md_core_pkg::QUIRK_SVP]    = 1'b1;
			"T-35036 ": quirk_hit[md_core_pkg::QUIRK_FMBUSY] = 1'b1;
			" GM 0000": quirk_hit[md_core_pkg::QUIRK_SRAM00] = 1'b1;

			// light gun titles
			"T-95096-": begin
				gun_type_hit  = 1'b1;
				gun_delay_hit = `MD_GUN_DELAY_W'd52;
			end
			"MK-1533 ": begin
				gun_type_hit  = 1'b0;
				gun_delay_hit = `MD_GUN_DELAY_W'd100;
			end
			default: ;
		endcase
	end

	////////////////////
	// result registers
	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `MD_GUN_DELAY_W'(`MD_GUN_DELAY_DEFAULT);
		end else if (load_start) begin
			// new image, forget the old title
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `MD_GUN_DELAY_W'(`MD_GUN_DELAY_DEFAULT);
		end else if (id_done) begin
			quirks           <= quirks | quirk_hit;   // sticky until next load
			gun_type         <= gun_type_hit;
			gun_sensor_delay <= gun_delay_hit;
		end
	end

	// quirks only move in answer to the header decoder's pulses
	a_quirks_on_pulse: assert property (
		@(posedge clk_sys) disable iff (!pll_core_locked)
		!$stable(quirks) |-> $past(id_done || load_start)
	);

endmodule

`default_nettype wire

// ==== core_settings_regs.sv ====
// core settings register bank
// Wishbone classic slave with the option bits, quirk read-back,
// the region choice from the header and the timed core reset

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module core_settings_regs (
	input  wire                        clk_sys,
	input  wire                        pll_core_locked,
	input  wire                        wb_cyc,
	input  wire                        wb_stb,
	input  wire                        wb_we,
	input  wire [`MD_WB_ADDR_W-1:0]    wb_adr,
	input  wire [`MD_WB_DATA_W-1:0]    wb_dat_w,
	output logic [`MD_WB_DATA_W-1:0]   wb_dat_r,
	output logic                       wb_ack,
	input  wire                        hdr_j,
	input  wire                        hdr_u,
	input  wire                        hdr_e,
	input  wire                        hdr_ready,
	input  wire [`MD_QUIRK_W-1:0]      quirks,
	input  wire                        gun_type,
	input  wire [`MD_GUN_DELAY_W-1:0]  gun_sensor_delay,
	output logic                       multitap,
	output logic                       ar_correction,
	output logic                       composite,
	output logic                       obj_limit_high,
	output logic                       fm_enable,
	output logic                       psg_enable,
	output logic                       hifi_pcm,
	output logic                       fm_chip,
	output logic [1:0]                 audio_filter,
	output logic [1:0]                 cpu_turbo,
	output md_core_pkg::region_e       region,
	output wire                        core_reset_n
);

	localparam int CNT_W = $clog2(`MD_RESET_HOLD + 1);

	logic             wb_wr;
	logic             region_hold;    // hdr_ready, one cycle late
	logic [CNT_W-1:0] reset_cnt;

	assign wb_wr        = wb_ack & wb_cyc & wb_stb & wb_we;   // commit on the ack cycle
	assign core_reset_n = !(reset_cnt != '0 || region_hold);

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			wb_ack         <= 1'b0;
			multitap       <= 1'b0;
			ar_correction  <= 1'b0;
			composite      <= 1'b0;
			obj_limit_high <= 1'b1;
			fm_enable      <= 1'b1;
			psg_enable     <= 1'b1;
			hifi_pcm       <= 1'b1;
			fm_chip        <= 1'b0;
			audio_filter   <= 2'd0;
			cpu_turbo      <= 2'd0;
			reset_cnt      <= '0;
			region_hold    <= 1'b0;
			region         <= md_core_pkg::REGION_US;
		end else begin
			wb_ack      <= wb_cyc & wb_stb & ~wb_ack;  // single cycle, no wait states
			region_hold <= hdr_ready;

			if (wb_wr && wb_adr == `MD_REG_RESET && wb_dat_w != '0)
				reset_cnt <= CNT_W'(`MD_RESET_HOLD);
			else if (reset_cnt != '0)
				reset_cnt <= reset_cnt - 1'b1;

			if (wb_wr) begin
				case (wb_adr)
					`MD_REG_MULTITAP:     multitap       <= wb_dat_w[0];
					`MD_REG_AR_CORRECT:   ar_correction  <= wb_dat_w[0];
					`MD_REG_COMPOSITE:    composite      <= wb_dat_w[0];
					`MD_REG_OBJ_LIMIT:    obj_limit_high <= wb_dat_w[0];
					`MD_REG_FM:           fm_enable      <= wb_dat_w[0];
					`MD_REG_PSG:          psg_enable     <= wb_dat_w[0];
					`MD_REG_HIFI_PCM:     hifi_pcm       <= wb_dat_w[0];
					`MD_REG_FM_CHIP:      fm_chip        <= wb_dat_w[0];
					`MD_REG_AUDIO_FILTER: audio_filter   <= wb_dat_w[1:0];
					`MD_REG_TURBO:        cpu_turbo      <= wb_dat_w[1:0];
					default: ;
				endcase
			end

			// header just completed, US beats EU beats JP
			if (hdr_ready & ~region_hold) begin
				if (hdr_u)
					region <= md_core_pkg::REGION_US;
				else if (hdr_e)
					region <= md_core_pkg::REGION_EU;
				else if (hdr_j)
					region <= md_core_pkg::REGION_JP;
				else
					region <= md_core_pkg::REGION_US;
			end
		end
	end

	////////////////////
	// read mux
	always_comb begin
		case (wb_adr)
			`MD_REG_MULTITAP:     wb_dat_r = `MD_WB_DATA_W'(multitap);
			`MD_REG_AR_CORRECT:   wb_dat_r = `MD_WB_DATA_W'(ar_correction);
			`MD_REG_COMPOSITE:    wb_dat_r = `MD_WB_DATA_W'(composite);
			`MD_REG_OBJ_LIMIT:    wb_dat_r = `MD_WB_DATA_W'(obj_limit_high);
			`MD_REG_FM:           wb_dat_r = `MD_WB_DATA_W'(fm_enable);
			`MD_REG_PSG:          wb_dat_r = `MD_WB_DATA_W'(psg_enable);
			`MD_REG_HIFI_PCM:     wb_dat_r = `MD_WB_DATA_W'(hifi_pcm);
			`MD_REG_FM_CHIP:      wb_dat_r = `MD_WB_DATA_W'(fm_chip);
			`MD_REG_AUDIO_FILTER: wb_dat_r = `MD_WB_DATA_W'(audio_filter);
			`MD_REG_TURBO:        wb_dat_r = `MD_WB_DATA_W'(cpu_turbo);
			`MD_REG_REGION:       wb_dat_r = `MD_WB_DATA_W'(region);
			`MD_REG_QUIRKS:       wb_dat_r = `MD_WB_DATA_W'(quirks);
			`MD_REG_GUN:          wb_dat_r = `MD_WB_DATA_W'({gun_type, gun_sensor_delay});
			default:              wb_dat_r = '0;
		endcase
	end

	a_ack_follows_req: assert property (
		@(posedge clk_sys) disable iff (!pll_core_locked)
		wb_ack |-> $past(wb_cyc && wb_stb)
	);

endmodule

`default_nettype wire

// ==== pad_remap.sv ====
// controller remapper
// turns one 32-bit pad word into the 12-bit console joystick word,
// with an alternate button layout for the pad types in bits 31..29

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module pad_remap (
	input  wire                  clk_sys,
	input  wire                  pll_core_locked,
	input  wire [`MD_PAD_W-1:0]  cont_key,
	output logic [`MD_JOY_W-1:0] joystick
);

	logic                 alt_type;
	logic [`MD_JOY_W-1:0] joy_std;
	logic [`MD_JOY_W-1:0] joy_alt;

	assign alt_type = |cont_key[31:29];

	// Z Y X mode start B C A up down left right
	assign joy_std = {
		cont_key[9],  cont_key[6],  cont_key[8],
		cont_key[14], cont_key[15],
		cont_key[4],  cont_key[5],  cont_key[7],
		cont_key[0],  cont_key[1],  cont_key[2],  cont_key[3]
	};

	assign joy_alt = {
		cont_key[10], cont_key[7],  cont_key[6],   // shoulder Z, face X/Y swapped
		cont_key[14], cont_key[15],
		cont_key[11], cont_key[5],  cont_key[4],
		cont_key[0],  cont_key[1],  cont_key[2],  cont_key[3]
	};

	always_ff @(posedge clk_sys or negedge pll_core_locked) begin
		if (!pll_core_locked)
			joystick <= '0;
		else
			joystick <= alt_type ? joy_alt : joy_std;
	end

endmodule

`default_nettype wire

// ==== md_core_top.sv ====
// MD core cartridge control top level
// header decode, quirk lookup and settings registers in a chain,
// plus a remapper for each of the two pads

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module md_core_top (
	input  wire                       clk_sys,
	input  wire                       pll_core_locked,
	// rom download
	input  wire                       loading,
	input  wire                       rom_wr,
	input  wire [`MD_ROM_ADDR_W-1:0]  rom_addr,
	input  wire [`MD_ROM_DATA_W-1:0]  rom_data,
	// wishbone slave
	input  wire                       wb_cyc,
	input  wire                       wb_stb,
	input  wire                       wb_we,
	input  wire [`MD_WB_ADDR_W-1:0]   wb_adr,
	input  wire [`MD_WB_DATA_W-1:0]   wb_dat_w,
	output wire [`MD_WB_DATA_W-1:0]   wb_dat_r,
	output wire                       wb_ack,
	// pads
	input  wire [`MD_PAD_W-1:0]       cont1_key,
	input  wire [`MD_PAD_W-1:0]       cont2_key,
	output wire [`MD_JOY_W-1:0]       joystick_1,
	output wire [`MD_JOY_W-1:0]       joystick_2,
	// settings to the console core
	output wire                       multitap,
	output wire                       ar_correction,
	output wire                       composite,
	output wire                       obj_limit_high,
	output wire                       fm_enable,
	output wire                       psg_enable,
	output wire                       hifi_pcm,
	output wire                       fm_chip,
	output wire [1:0]                 audio_filter,
	output wire [1:0]                 cpu_turbo,
	output wire [1:0]                 region,
	output wire                       core_reset_n
);

	wire [`MD_CART_ID_W-1:0]   cart_id;
	wire                       id_done;
	wire                       load_start;
	wire                       hdr_j;
	wire                       hdr_u;
	wire                       hdr_e;
	wire                       hdr_ready;
	wire [`MD_QUIRK_W-1:0]     quirks;
	wire                       gun_type;
	wire [`MD_GUN_DELAY_W-1:0] gun_sensor_delay;

	////////////////////
	// decode
	rom_header_decode u_decode (
		.clk_sys, .pll_core_locked,
		.loading, .rom_wr, .rom_addr, .rom_data,
		.cart_id, .id_done, .load_start,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready
	);

	// execute
	cart_quirk_lookup u_lookup (
		.clk_sys, .pll_core_locked,
		.cart_id, .id_done, .load_start,
		.quirks, .gun_type, .gun_sensor_delay
	);

	// result, served on the bus
	core_settings_regs u_regs (
		.clk_sys, .pll_core_locked,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready,
		.quirks, .gun_type, .gun_sensor_delay,
		.multitap, .ar_correction, .composite, .obj_limit_high,
		.fm_enable, .psg_enable, .hifi_pcm, .fm_chip,
		.audio_filter, .cpu_turbo,
		.region, .core_reset_n
	);

	////////////////////
	// pads
	pad_remap u_pad1 (
		.clk_sys, .pll_core_locked,
		.cont_key (cont1_key),
		.joystick (joystick_1)
	);

	pad_remap u_pad2 (
		.clk_sys, .pll_core_locked,
		.cont_key (cont2_key),
		.joystick (joystick_2)
	);

endmodule

`default_nettype wire

// ==== tb_md_core_tasks.svh ====
// MD core testbench tasks
// value check, Wishbone and ROM drivers, and the directed tests

`ifndef TB_MD_CORE_TASKS_SVH
`define TB_MD_CORE_TASKS_SVH

////////////////////
// check and drivers

task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
	if (got !== expected) begin
		$display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
			$time, what, got, expected);
		$display("Done: errors found");
		$fatal(1, "stopped at first mismatch");
	end
endtask

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Done: errors found");
	$fatal(1, "run aborted");
endtask

// returns on the negedge where ack is seen
task automatic wait_ack();
	int cycles;
	cycles = 0;
	do begin
		@(negedge clk_sys);
		cycles++;
	end while (!wb_ack && cycles < 8);
	if (!wb_ack)
		abort_run("no Wishbone ack within 8 cycles of the request");
endtask

task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
	@(posedge clk_sys);
	wb_cyc   <= 1'b1;
	wb_stb   <= 1'b1;
	wb_we    <= 1'b1;
	wb_adr   <= adr;
	wb_dat_w <= data;
	wait_ack();
	@(posedge clk_sys);      // write lands on this edge
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
	wb_we  <= 1'b0;
endtask

task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
	@(posedge clk_sys);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we  <= 1'b0;
	wb_adr <= adr;
	wait_ack();
	data = wb_dat_r;
	@(posedge clk_sys);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
endtask

task automatic rom_write_word(input int addr, input logic [15:0] data);
	@(posedge clk_sys);
	rom_wr   <= 1'b1;
	rom_addr <= addr[`MD_ROM_ADDR_W-1:0];
	rom_data <= data;
	@(posedge clk_sys);
	rom_wr <= 1'b0;
endtask

task automatic begin_load();
	@(posedge clk_sys);
	loading <= 1'b1;
	repeat (2) @(posedge clk_sys);   // let load_start clear the old image
endtask

task automatic end_load();
	@(posedge clk_sys);
	loading <= 1'b0;
endtask

task automatic wait_reset_release(input int max_cycles);
	int n;
	n = 0;
	do begin
		@(negedge clk_sys);
		n++;
	end while (!core_reset_n && n < max_cycles);
	check(32'(core_reset_n), 32'd1, "core reset released after loading fell");
endtask

// product code sits in header bytes 0x183..0x18A
function automatic logic [7:0] code_byte(input logic [63:0] code, input int addr);
	if (addr < 'h183 || addr > 'h18A)
		return 8'h20;
	return code[63 - 8 * (addr - 'h183) -: 8];
endfunction

task automatic write_product_code(input logic [63:0] code);
	for (int a = `MD_HDR_ID_FIRST; a <= `MD_HDR_ID_LAST; a += 2)
		rom_write_word(a, {code_byte(code, a + 1), code_byte(code, a)});
	rom_write_word(`MD_HDR_ID_DONE, 16'h2020);   // lookup trigger
endtask

////////////////////
// directed tests

task automatic registers_after_reset();
	logic [7:0]  adr   [10];
	logic [1:0]  rst_v [10];
	logic [1:0]  new_v [10];
	logic [31:0] rdata;
	adr   = '{`MD_REG_MULTITAP, `MD_REG_AR_CORRECT, `MD_REG_COMPOSITE, `MD_REG_OBJ_LIMIT,
		`MD_REG_FM, `MD_REG_PSG, `MD_REG_HIFI_PCM, `MD_REG_FM_CHIP,
		`MD_REG_AUDIO_FILTER, `MD_REG_TURBO};
	rst_v = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0};
	new_v = '{2'd1, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd1, 2'd3, 2'd2};

	for (int i = 0; i < 10; i++) begin
		wb_read(adr[i], rdata);
		check(rdata, 32'(rst_v[i]), $sformatf("option 0x%0h after reset", adr[i]));
	end
	check(32'(option_ports), 32'(expected_options(rst_v)), "option ports after reset");
	wb_read(`MD_REG_REGION, rdata);
	check(rdata, 32'(md_core_pkg::REGION_US), "region after reset");
	check(32'(core_reset_n), 32'd1, "core reset after reset");

	for (int i = 0; i < 10; i++)
		wb_write(adr[i], 32'(new_v[i]));
	for (int i = 0; i < 10; i++) begin
		wb_read(adr[i], rdata);
		check(rdata, 32'(new_v[i]), $sformatf("option 0x%0h read back", adr[i]));
	end
	check(32'(option_ports), 32'(expected_options(new_v)), "option ports after writes");

	wb_read(8'h3C, rdata);
	check(rdata, 32'd0, "unmapped read");
	wb_read(`MD_REG_RESET, rdata);   // write only
	check(rdata, 32'd0, "reset register read");
endtask

task automatic load_region_header(input logic [15:0] word, input md_core_pkg::region_e exp,
	input string what);
	logic [31:0] rdata;
	begin_load();
	rom_write_word(`MD_HDR_REGION0, word);
	rom_write_word(`MD_HDR_REGION1, 16'h2020);
	rom_write_word(`MD_HDR_END, 16'h0000);
	end_load();
	wait_reset_release(3);
	check(32'(region), 32'(exp), {"region port, ", what});
	wb_read(`MD_REG_REGION, rdata);
	check(rdata, 32'(exp), {"region register, ", what});
endtask

task automatic region_priority();
	load_region_header(16'h204A, md_core_pkg::REGION_JP, "J in low byte");
	load_region_header(16'h4520, md_core_pkg::REGION_EU, "E in high byte");
	load_region_header(16'h2034, md_core_pkg::REGION_US, "digit 4");
	// 'B' nibble 2 minus 7 wraps to 0xB, E and J set
	load_region_header(16'h2042, md_core_pkg::REGION_EU, "hex B");
endtask

task automatic region_reset_hold();
	begin_load();
	rom_write_word(`MD_HDR_END, 16'h0000);
	repeat (2) @(negedge clk_sys);   // hdr_ready, then the hold
	check(32'(core_reset_n), 32'd0, "core reset after header end");
	repeat (5) @(negedge clk_sys);
	check(32'(core_reset_n), 32'd0, "core reset while still loading");
	end_load();
	wait_reset_release(3);
	check(32'(region), 32'(md_core_pkg::REGION_US), "region with no region field");
endtask

task automatic quirk_table();
	logic [31:0] rdata;
	logic [31:0] eeprom_bit;
	eeprom_bit = 32'd1 << md_core_pkg::QUIRK_EEPROM;

	begin_load();
	write_product_code("MK-1215 ");
	wb_read(`MD_REG_QUIRKS, rdata);
	check(rdata, eeprom_bit, "quirks for MK-1215");
	wb_read(`MD_REG_GUN, rdata);
	check(rdata, 32'(GUN_DEFAULT), "gun for MK-1215");
	write_product_code("T-95096-");
	wb_read(`MD_REG_GUN, rdata);
	check(rdata, 32'h100 | 32'd52, "gun for T-95096-");
	wb_read(`MD_REG_QUIRKS, rdata);
	check(rdata, eeprom_bit, "quirks kept within one load");
	end_load();

	begin_load();
	wb_read(`MD_REG_QUIRKS, rdata);
	check(rdata, 32'd0, "quirks cleared by new load");
	wb_read(`MD_REG_GUN, rdata);
	check(rdata, 32'(GUN_DEFAULT), "gun defaults on new load");
	write_product_code("MK-1533 ");
	wb_read(`MD_REG_GUN, rdata);
	check(rdata, 32'd100, "gun for MK-1533");
	write_product_code("XX-00000");
	wb_read(`MD_REG_QUIRKS, rdata);
	check(rdata, 32'd0, "quirks for unknown code");
	wb_read(`MD_REG_GUN, rdata);
	check(rdata, 32'(GUN_DEFAULT), "gun for unknown code");
	end_load();
endtask

task automatic timed_core_reset();
	int low_cycles;
	check(32'(core_reset_n), 32'd1, "core running before reset request");
	wb_write(`MD_REG_RESET, 32'd0);
	@(negedge clk_sys);
	check(32'(core_reset_n), 32'd1, "zero write to reset register");

	wb_write(`MD_REG_RESET, 32'd1);
	low_cycles = 0;
	do begin
		@(negedge clk_sys);
		if (!core_reset_n)
			low_cycles++;
	end while (!core_reset_n && low_cycles < 4 * `MD_RESET_HOLD);
	check(32'(low_cycles), 32'(`MD_RESET_HOLD), "core reset hold length");
endtask

task automatic pad_layouts();
	logic [31:0] key1;
	logic [31:0] key2;
	logic [31:0] prev_key1;
	logic [31:0] prev_key2;
	prev_key1 = cont1_key;
	prev_key2 = cont2_key;
	for (int i = 0; i < PAD_VECTORS; i++) begin
		key1 = $random(seed);
		key2 = $random(seed);
		if (i % 2 == 0) begin
			key1[31:29] = 3'b000;
			key2[31:29] = 3'(i % 7 + 1);
		end else begin
			key1[31:29] = 3'(i % 7 + 1);
			key2[31:29] = 3'b000;
		end
		@(posedge clk_sys);
		cont1_key <= key1;
		cont2_key <= key2;
		@(negedge clk_sys);   // new key not yet through the register
		check(32'(joystick_1), 32'(expected_joystick(prev_key1)), "joystick_1 before the edge");
		check(32'(joystick_2), 32'(expected_joystick(prev_key2)), "joystick_2 before the edge");
		@(posedge clk_sys);   // registered in the remapper
		@(negedge clk_sys);
		check(32'(joystick_1), 32'(expected_joystick(key1)), "joystick_1 layout");
		check(32'(joystick_2), 32'(expected_joystick(key2)), "joystick_2 layout");
		prev_key1 = key1;
		prev_key2 = key2;
	end
endtask

`endif

// ==== tb_md_core.sv ====
// MD core cartridge control testbench
// drives ROM downloads, the Wishbone register bank and both pads,
// checking results against the header, register and layout rules

`timescale 1ns/100ps
`default_nettype none
`include "md_core_config.svh"

module tb_md_core;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int PAD_VECTORS  = 24;
	localparam int GUN_DEFAULT  = `MD_GUN_DELAY_DEFAULT;   // type 0 in bit 8

	// rough cycle cost of each test
	localparam int REGS_CYCLES      = 240;
	localparam int REGION_CYCLES    = 4 * 30;
	localparam int HOLD_CYCLES      = 30;
	localparam int QUIRK_CYCLES     = 5 * 40;
	localparam int RESET_REQ_CYCLES = 20 + 4 * `MD_RESET_HOLD;
	localparam int PAD_CYCLES       = PAD_VECTORS * 4;
	localparam int TEST_CYCLES      = RESET_CYCLES + REGS_CYCLES + REGION_CYCLES
		+ HOLD_CYCLES + QUIRK_CYCLES + RESET_REQ_CYCLES + PAD_CYCLES;
	localparam int MARGIN_CYCLES    = 200;
	localparam longint WATCHDOG_NS  = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic                      clk_sys;
	logic                      pll_core_locked;
	logic                      loading;
	logic                      rom_wr;
	logic [`MD_ROM_ADDR_W-1:0] rom_addr;
	logic [`MD_ROM_DATA_W-1:0] rom_data;
	logic                      wb_cyc;
	logic                      wb_stb;
	logic                      wb_we;
	logic [`MD_WB_ADDR_W-1:0]  wb_adr;
	logic [`MD_WB_DATA_W-1:0]  wb_dat_w;
	wire  [`MD_WB_DATA_W-1:0]  wb_dat_r;
	wire                       wb_ack;
	logic [`MD_PAD_W-1:0]      cont1_key;
	logic [`MD_PAD_W-1:0]      cont2_key;
	wire  [`MD_JOY_W-1:0]      joystick_1;
	wire  [`MD_JOY_W-1:0]      joystick_2;
	wire                       multitap;
	wire                       ar_correction;
	wire                       composite;
	wire                       obj_limit_high;
	wire                       fm_enable;
	wire                       psg_enable;
	wire                       hifi_pcm;
	wire                       fm_chip;
	wire  [1:0]                audio_filter;
	wire  [1:0]                cpu_turbo;
	wire  [1:0]                region;
	wire                       core_reset_n;
	logic [11:0]               option_ports;    // same order as the register map

	integer seed;

	assign option_ports = {multitap, ar_correction, composite, obj_limit_high,
		fm_enable, psg_enable, hifi_pcm, fm_chip, audio_filter, cpu_turbo};

	md_core_top dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////
	// expected values

	// console joystick word, Z Y X mode start B C A up down left right
	function automatic logic [11:0] expected_joystick(input logic [31:0] key);
		int          src [12];
		logic [11:0] joy;
		if (|key[31:29])
			src = '{10, 7, 6, 14, 15, 11, 5, 4, 0, 1, 2, 3};   // alternate pad
		else
			src = '{9, 6, 8, 14, 15, 4, 5, 7, 0, 1, 2, 3};
		for (int b = 0; b < 12; b++)
			joy[11 - b] = key[src[b]];
		return joy;
	endfunction

	// eight 1-bit options, then audio filter and turbo
	function automatic logic [11:0] expected_options(input logic [1:0] v [10]);
		logic [11:0] ports;
		for (int i = 0; i < 8; i++)
			ports[11 - i] = v[i][0];
		ports[3:2] = v[8];
		ports[1:0] = v[9];
		return ports;
	endfunction

	`include "tb_md_core_tasks.svh"

	////////////////////
	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests still running after %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk_sys         = 1'b0;
		pll_core_locked = 1'b0;
		loading         = 1'b0;
		rom_wr          = 1'b0;
		rom_addr        = '0;
		rom_data        = '0;
		wb_cyc          = 1'b0;
		wb_stb          = 1'b0;
		wb_we           = 1'b0;
		wb_adr          = '0;
		wb_dat_w        = '0;
		cont1_key       = '0;
		cont2_key       = '0;
		seed            = 17565;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		pll_core_locked <= 1'b1;
		@(posedge clk_sys);

		registers_after_reset();
		region_priority();
		region_reset_hold();
		quirk_table();
		timed_core_reset();
		pad_layouts();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
md_core_pkg.sv
rom_header_decode.sv
cart_quirk_lookup.sv
core_settings_regs.sv
pad_remap.sv
md_core_top.sv
tb_md_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MD core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_md_core \
	--Mdir obj_dir -o tb_md_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_md_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
